// ==== compile.f ====
+incdir+dv
rtl/pdp8_pkg.sv
rtl/core_memory.sv
rtl/memory_arbiter.sv
rtl/front_panel.sv
rtl/cpu_datapath.sv
rtl/cpu_sequencer.sv
rtl/pdp8_top.sv
dv/pdp8_tb.sv

// ==== Makefile ====
# Verilator build and run of the PDP-8 testbench
VERILATOR ?= verilator
TOP       ?= pdp8_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing
PASS_TEXT ?= all tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard dv/*.svh)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BINARY)
	@out="$$($(BINARY))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/pdp8_tb_tasks.svh ====
// ####################
// Panel drive tasks, program loader, typed compares and directed tests
// ####################

task automatic compare_word(input pdp8_pkg::word_t got, input pdp8_pkg::word_t exp,
                            input string what);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("Fail at %0t ns: %s is %04o, expected %04o", $time, what, got, exp);
  end
endtask

task automatic compare_addr(input pdp8_pkg::addr_t got, input pdp8_pkg::addr_t exp,
                            input string what);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("Fail at %0t ns: %s is %04o, expected %04o", $time, what, got, exp);
  end
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic report_test(input string name, input int errs_before);
  test_count++;
  $display("Test %-16s finished with %0d errors", name, error_count - errs_before);
endtask

// Memory-reference word; a target above page zero is taken as the current page
function automatic pdp8_pkg::word_t mri(input pdp8_pkg::opcode_e op, input logic ind,
                                        input pdp8_pkg::addr_t target);
  pdp8_pkg::instr_u w;
  w.mem_ref.opcode       = op;
  w.mem_ref.indirect     = ind;
  w.mem_ref.current_page = (target[pdp8_pkg::ADDR_W-1:7] != '0);
  w.mem_ref.offset       = target[6:0];
  return w;
endfunction

// Group 1 reference: clear, complement, increment, then rotate through the link
function automatic logic [12:0] opr_model(input pdp8_pkg::word_t a_in, input logic l_in,
                                          input pdp8_pkg::instr_u op);
  pdp8_pkg::word_t a;
  logic            l;
  logic            out_bit;
  a = a_in;
  l = l_in;
  if (op.operate.cla) a = '0;
  if (op.operate.cll) l = 1'b0;
  if (op.operate.cma) a = ~a;
  if (op.operate.cml) l = ~l;
  if (op.operate.iac) begin
    if (a == 12'o7777) l = ~l;           // Carry out of the AC
    a = a + 12'd1;
  end
  if (op.operate.rar) begin
    out_bit = a[0];
    a       = {l, a[11:1]};
    l       = out_bit;
  end
  if (op.operate.ral) begin
    out_bit = a[11];
    a       = {a[10:0], l};
    l       = out_bit;
  end
  return {l, a};
endfunction

task automatic set_panel_addr(input pdp8_pkg::addr_t a);
  @(posedge clock);
  sr        <= a;
  load_addr <= 1'b1;
  @(posedge clock);
  load_addr <= 1'b0;
endtask

// One deposit or examine; waits for panel_busy to fall and counts panel_valid
task automatic panel_access(input logic write, input pdp8_pkg::word_t data,
                            output pdp8_pkg::word_t rdata, output int pulses);
  pulses = 0;
  @(posedge clock);
  sr <= data;
  if (write)
    deposit <= 1'b1;
  else
    examine <= 1'b1;
  @(posedge clock);
  deposit <= 1'b0;
  examine <= 1'b0;
  do begin
    @(negedge clock);
    if (panel_valid) pulses++;
  end while (panel_busy);
  rdata = panel_data;
  @(negedge clock);
  if (panel_valid) pulses++;             // A second pulse would show here
endtask

task automatic deposit_word(input pdp8_pkg::word_t data);
  pdp8_pkg::word_t unused_data;
  int              pulses;
  panel_access(1'b1, data, unused_data, pulses);
  if (pulses != 0) begin
    error_count++;
    $display("Fail at %0t ns: panel_valid pulsed %0d times on a deposit", $time, pulses);
  end
endtask

task automatic examine_word(output pdp8_pkg::word_t data);
  int pulses;
  panel_access(1'b0, '0, data, pulses);
  if (pulses != 1) begin
    error_count++;
    $display("Fail at %0t ns: panel_valid pulsed %0d times on an examine", $time, pulses);
  end
endtask

task automatic deposit_at(input pdp8_pkg::addr_t a, input pdp8_pkg::word_t data);
  set_panel_addr(a);
  deposit_word(data);
endtask

task automatic examine_at(input pdp8_pkg::addr_t a, output pdp8_pkg::word_t data);
  set_panel_addr(a);
  examine_word(data);
endtask

task automatic load_program(input pdp8_pkg::addr_t start);
  set_panel_addr(start);
  foreach (prog[i])
    deposit_word(prog[i]);
  prog.delete();
endtask

task automatic load_pc_to(input pdp8_pkg::addr_t a);
  @(posedge clock);
  sr      <= a;
  load_pc <= 1'b1;
  @(posedge clock);
  load_pc <= 1'b0;
  do @(negedge clock); while (!halted);
endtask

// Run or single step, then wait for the CPU to return to idle
task automatic start_cpu(input logic single);
  @(posedge clock);
  if (single)
    step <= 1'b1;
  else
    run <= 1'b1;
  @(posedge clock);
  run  <= 1'b0;
  step <= 1'b0;
  @(negedge clock);
  compare_bit(halted, 1'b0, "halted once the CPU has started");
  while (!halted) @(negedge clock);
  @(negedge clock);                      // CPU stays in idle with no strobe
endtask

task automatic test_deposit_examine();
  pdp8_pkg::word_t words[32];
  pdp8_pkg::word_t got;
  int              errs;
  errs = error_count;
  set_panel_addr(12'o0200);
  for (int i = 0; i < 32; i++) begin
    words[i] = pdp8_pkg::word_t'($random(seed));
    deposit_word(words[i]);
  end
  set_panel_addr(12'o0200);
  for (int i = 0; i < 32; i++) begin
    examine_word(got);
    compare_word(got, words[i], $sformatf("word at %04o", 12'o0200 + i));
  end
  report_test("deposit_examine", errs);
endtask

task automatic test_and_tad_dca();
  pdp8_pkg::word_t zero_val;
  pdp8_pkg::word_t page_val;
  pdp8_pkg::word_t mask;
  pdp8_pkg::word_t last_val;
  pdp8_pkg::word_t stored;
  logic [12:0]     sum;
  int              errs;
  errs     = error_count;
  zero_val = 12'o3456;
  page_val = 12'o5670;
  mask     = 12'o7070;
  last_val = 12'o0123;
  sum      = {1'b0, zero_val} + {1'b0, page_val};   // Link starts clear
  deposit_at(12'o0050, zero_val);
  deposit_at(12'o0051, last_val);
  deposit_at(12'o0240, page_val);
  deposit_at(12'o0241, mask);
  deposit_at(12'o0242, 12'o7777);
  prog.push_back(12'o7300);
  prog.push_back(mri(pdp8_pkg::TAD, 1'b0, 12'o0050));
  prog.push_back(mri(pdp8_pkg::TAD, 1'b0, 12'o0240));
  prog.push_back(mri(pdp8_pkg::AND, 1'b0, 12'o0241));
  prog.push_back(mri(pdp8_pkg::DCA, 1'b0, 12'o0242));
  prog.push_back(mri(pdp8_pkg::TAD, 1'b0, 12'o0051));
  prog.push_back(pdp8_pkg::HLT_WORD);
  load_program(12'o0200);
  load_pc_to(12'o0200);
  start_cpu(1'b0);
  compare_word(ac, last_val, "AC after DCA and TAD");
  compare_bit(link, sum[12], "link after TAD carry");
  compare_bit(halted, 1'b1, "halted after HLT");
  compare_addr(pc, 12'o0207, "PC after HLT");
  examine_at(12'o0242, stored);
  compare_word(stored, sum[11:0] & mask, "word stored by DCA");
  report_test("and_tad_dca", errs);
endtask

task automatic test_indirect_jms_jmp();
  pdp8_pkg::word_t ret_addr;
  int              errs;
  errs = error_count;
  deposit_at(12'o0020, 12'o0700);        // Pointer to the subroutine
  deposit_at(12'o0620, 12'o0011);
  deposit_at(12'o0720, 12'o0100);
  prog.push_back(12'o7300);
  prog.push_back(mri(pdp8_pkg::JMS, 1'b1, 12'o0020));
  prog.push_back(mri(pdp8_pkg::JMP, 1'b0, 12'o0610));
  load_program(12'o0600);
  prog.push_back(mri(pdp8_pkg::TAD, 1'b0, 12'o0620));
  prog.push_back(pdp8_pkg::HLT_WORD);
  load_program(12'o0610);
  prog.push_back(12'o0000);              // Return address slot
  prog.push_back(mri(pdp8_pkg::TAD, 1'b0, 12'o0720));
  prog.push_back(mri(pdp8_pkg::JMP, 1'b1, 12'o0700));
  load_program(12'o0700);
  load_pc_to(12'o0600);
  start_cpu(1'b0);
  compare_word(ac, 12'o0100 + 12'o0011, "AC after subroutine and return");
  compare_addr(pc, 12'o0612, "PC after HLT");
  compare_bit(halted, 1'b1, "halted after HLT");
  examine_at(12'o0700, ret_addr);
  compare_word(ret_addr, 12'o0602, "return address stored by JMS");
  report_test("indirect_jms_jmp", errs);
endtask

task automatic test_isz_loop();
  pdp8_pkg::word_t counter;
  pdp8_pkg::word_t start_val;
  int              passes;
  int              errs;
  errs      = error_count;
  start_val = 12'o7775;
  passes    = 4096 - int'(start_val);
  deposit_at(12'o1020, start_val);
  prog.push_back(12'o7300);
  prog.push_back(12'o7001);
  prog.push_back(mri(pdp8_pkg::ISZ, 1'b0, 12'o1020));
  prog.push_back(mri(pdp8_pkg::JMP, 1'b0, 12'o1001));
  prog.push_back(pdp8_pkg::HLT_WORD);
  load_program(12'o1000);
  load_pc_to(12'o1000);
  start_cpu(1'b0);
  compare_word(ac, pdp8_pkg::word_t'(passes), "loop count in AC");
  compare_addr(pc, 12'o1005, "PC after skip and HLT");
  examine_at(12'o1020, counter);
  compare_word(counter, '0, "ISZ counter");
  report_test("isz_loop", errs);
endtask

task automatic check_operate(input pdp8_pkg::word_t op, input pdp8_pkg::word_t ac_in,
                             input logic link_in);
  logic [12:0] exp;
  exp = opr_model(ac_in, link_in, op);
  prog.push_back(12'o7300);
  prog.push_back(mri(pdp8_pkg::TAD, 1'b0, 12'o0410));
  prog.push_back(link_in ? 12'o7020 : 12'o7000);  // CML or NOP sets the start link
  prog.push_back(op);
  prog.push_back(pdp8_pkg::HLT_WORD);
  load_program(12'o0400);
  deposit_at(12'o0410, ac_in);
  load_pc_to(12'o0400);
  start_cpu(1'b0);
  compare_word(ac, exp[11:0], $sformatf("AC after operate %04o", op));
  compare_bit(link, exp[12], $sformatf("link after operate %04o", op));
endtask

task automatic test_group1_operate();
  int errs;
  errs = error_count;
  check_operate(12'o7200, 12'o5252, 1'b1);
  check_operate(12'o7100, 12'o1234, 1'b1);
  check_operate(12'o7040, 12'o0707, 1'b0);
  check_operate(12'o7020, 12'o4321, 1'b0);
  check_operate(12'o7001, 12'o7777, 1'b0);
  check_operate(12'o7010, 12'o0001, 1'b1);
  check_operate(12'o7004, 12'o4000, 1'b0);
  check_operate(12'o7041, 12'o0005, 1'b0);
  check_operate(12'o7240, 12'o1111, 1'b1);
  check_operate(12'o7301, 12'o6543, 1'b1);
  check_operate(12'o7030, 12'o2222, 1'b0);
  check_operate(12'o7005, 12'o3777, 1'b1);
  report_test("group1_operate", errs);
endtask

task automatic test_single_step();
  int errs;
  errs = error_count;
  deposit_at(12'o1210, 12'o0042);
  prog.push_back(12'o7300);
  prog.push_back(mri(pdp8_pkg::TAD, 1'b0, 12'o1210));
  prog.push_back(12'o7001);
  prog.push_back(pdp8_pkg::HLT_WORD);
  load_program(12'o1200);
  load_pc_to(12'o1200);
  start_cpu(1'b1);
  compare_addr(pc, 12'o1201, "PC after first step");
  compare_word(ac, '0, "AC after first step");
  compare_bit(halted, 1'b1, "halted after first step");
  start_cpu(1'b1);
  compare_addr(pc, 12'o1202, "PC after second step");
  compare_word(ac, 12'o0042, "AC after second step");
  compare_bit(halted, 1'b1, "halted after second step");
  start_cpu(1'b0);
  compare_addr(pc, 12'o1204, "PC after run to HLT");
  compare_word(ac, 12'o0043, "AC after run to HLT");
  report_test("single_step", errs);
endtask

// ==== dv/pdp8_tb.sv ====
// ####################
// Directed testbench for the PDP-8 top level, panel loading and CPU runs
// ####################
`default_nettype none

module pdp8_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 20000;   // Six tests of a few hundred cycles, with margin

  logic            clock;
  logic            resetN;
  pdp8_pkg::word_t sr;
  logic            load_pc;
  logic            load_addr;
  logic            deposit;
  logic            examine;
  logic            run;
  logic            step;
  pdp8_pkg::word_t ac;
  logic            link;
  pdp8_pkg::addr_t pc;
  logic            halted;
  pdp8_pkg::word_t panel_data;
  logic            panel_valid;
  logic            panel_busy;

  int error_count = 0;
  int check_count = 0;
  int test_count  = 0;
  int cycle_count = 0;
  int seed        = 70;

  pdp8_pkg::word_t prog[$];                // Words for the next program load

  pdp8_top #(.MEM_WORDS(4096)) UUT (
    .clock, .resetN, .sr, .load_pc, .load_addr, .deposit, .examine, .run, .step,
    .ac, .link, .pc, .halted, .panel_data, .panel_valid, .panel_busy
  );

  `include "pdp8_tb_tasks.svh"

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    resetN    = 1'b0;
    sr        = '0;
    load_pc   = 1'b0;
    load_addr = 1'b0;
    deposit   = 1'b0;
    examine   = 1'b0;
    run       = 1'b0;
    step      = 1'b0;
    repeat (16) @(posedge clock);
    resetN <= 1'b1;
    @(negedge clock);
    compare_bit(halted, 1'b1, "halted after reset");
    compare_bit(panel_busy, 1'b0, "panel_busy after reset");
    compare_bit(panel_valid, 1'b0, "panel_valid after reset");
    compare_word(ac, '0, "AC after reset");
    compare_bit(link, 1'b0, "link after reset");
    compare_addr(pc, '0, "PC after reset");

    test_deposit_examine();
    test_and_tad_dca();
    test_indirect_jms_jmp();
    test_isz_loop();
    test_group1_operate();
    test_single_step();

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/pdp8_top.sv ====
// ####################
// PDP-8 style CPU and front panel sharing one core memory
// ####################
`default_nettype none

module pdp8_top #(
  parameter int MEM_WORDS = 4096
) (
  input  logic             clock,
  input  logic             resetN,
  input  pdp8_pkg::word_t  sr,
  input  logic             load_pc,
  input  logic             load_addr,
  input  logic             deposit,
  input  logic             examine,
  input  logic             run,
  input  logic             step,
  output pdp8_pkg::word_t  ac,
  output logic             link,
  output pdp8_pkg::addr_t  pc,
  output logic             halted,
  output pdp8_pkg::word_t  panel_data,
  output logic             panel_valid,
  output logic             panel_busy
);

  pdp8_pkg::cpu_ctrl_t ctrl;
  pdp8_pkg::instr_u    ir;
  logic                mb_zero;

  pdp8_pkg::mem_req_t  cpu_req, panel_req;
  pdp8_pkg::mem_rsp_t  cpu_rsp, panel_rsp;

  logic                mem_we, mem_en;
  pdp8_pkg::addr_t     mem_addr;
  pdp8_pkg::word_t     mem_wdata, mem_rdata;

  cpu_sequencer u_sequencer (
    .clock, .resetN, .run, .step, .load_pc, .ir, .mb_zero,
    .mem_done (cpu_rsp.done),
    .ctrl, .halted
  );

  cpu_datapath u_datapath (
    .clock, .resetN, .ctrl, .sr,
    .rsp (cpu_rsp),
    .req (cpu_req),
    .ir, .mb_zero, .ac, .link, .pc
  );

  front_panel u_panel (
    .clock, .resetN, .sr, .load_addr, .deposit, .examine,
    .rsp (panel_rsp),
    .req (panel_req),
    .panel_data, .panel_valid, .panel_busy
  );

  memory_arbiter u_arbiter (
    .clock, .resetN, .cpu_req, .panel_req, .mem_rdata,
    .cpu_rsp, .panel_rsp, .mem_we, .mem_en, .mem_addr, .mem_wdata
  );

  core_memory #(.MEM_WORDS(MEM_WORDS)) u_memory (
    .clock,
    .en    (mem_en),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== rtl/cpu_sequencer.sv ====
// ####################
// Instruction FSM; drives Moore control words into the CPU datapath
// ####################
`default_nettype none

module cpu_sequencer (
  input  logic                clock,
  input  logic                resetN,
  input  logic                run,
  input  logic                step,
  input  logic                load_pc,
  input  pdp8_pkg::instr_u    ir,
  input  logic                mb_zero,
  input  logic                mem_done,
  output pdp8_pkg::cpu_ctrl_t ctrl,
  output logic                halted
);

  pdp8_pkg::cpu_state_e state, next_state;
  pdp8_pkg::cpu_state_e exec_state;     // First state of the decoded instruction
  pdp8_pkg::cpu_state_e end_state;      // Where an instruction goes when it finishes
  logic                 running;
  logic                 is_mem_ref;

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      state   <= pdp8_pkg::IDLE;
      running <= 1'b0;
    end else begin
      state <= next_state;
      if (state == pdp8_pkg::IDLE && (run || step))
        running <= run;                 // Step runs one instruction only
    end
  end

  assign halted     = (state == pdp8_pkg::IDLE);
  assign end_state  = running ? pdp8_pkg::FETCH : pdp8_pkg::IDLE;
  assign is_mem_ref = (ir.mem_ref.opcode != pdp8_pkg::IOT) &&
                      (ir.mem_ref.opcode != pdp8_pkg::OPR);

  always_comb begin
    case (ir.mem_ref.opcode)
      pdp8_pkg::AND: exec_state = pdp8_pkg::AND_RD;
      pdp8_pkg::TAD: exec_state = pdp8_pkg::TAD_RD;
      pdp8_pkg::ISZ: exec_state = pdp8_pkg::ISZ_RD;
      pdp8_pkg::DCA: exec_state = pdp8_pkg::DCA_WR;
      pdp8_pkg::JMS: exec_state = pdp8_pkg::JMS_WR;
      pdp8_pkg::JMP: exec_state = pdp8_pkg::JMP_1;
      default:       exec_state = pdp8_pkg::OPR_1;    // IOT falls through as a no-op
    endcase
  end

  always_comb begin
    next_state = state;
    case (state)
      pdp8_pkg::IDLE: begin
        if (run || step)
          next_state = pdp8_pkg::FETCH;
        else if (load_pc)
          next_state = pdp8_pkg::LD_PC;
      end
      pdp8_pkg::LD_PC:  next_state = pdp8_pkg::IDLE;
      pdp8_pkg::FETCH:  if (mem_done) next_state = pdp8_pkg::DECODE;
      pdp8_pkg::DECODE: begin
        if (pdp8_pkg::word_t'(ir) == pdp8_pkg::HLT_WORD)
          next_state = pdp8_pkg::IDLE;
        else if (is_mem_ref && ir.mem_ref.indirect)
          next_state = pdp8_pkg::EA_IND;
        else
          next_state = exec_state;
      end
      pdp8_pkg::EA_IND:  if (mem_done) next_state = exec_state;
      pdp8_pkg::ISZ_RD:  if (mem_done) next_state = pdp8_pkg::ISZ_INC;
      pdp8_pkg::ISZ_INC: next_state = pdp8_pkg::ISZ_WR;
      pdp8_pkg::ISZ_WR:  if (mem_done) next_state = pdp8_pkg::ISZ_SKIP;
      pdp8_pkg::AND_RD, pdp8_pkg::TAD_RD, pdp8_pkg::DCA_WR, pdp8_pkg::JMS_WR:
        if (mem_done) next_state = end_state;
      pdp8_pkg::ISZ_SKIP, pdp8_pkg::JMP_1, pdp8_pkg::OPR_1:
        next_state = end_state;
      default: next_state = pdp8_pkg::IDLE;
    endcase
  end

  always_comb begin
    ctrl = '{ac_op:   pdp8_pkg::AC_NC,
             pc_op:   pdp8_pkg::PC_NC,
             ea_op:   pdp8_pkg::EA_NC,
             rd_dest: pdp8_pkg::RD_NONE,
             wd_sel:  pdp8_pkg::WD_AC,
             ad_sel:  pdp8_pkg::AD_PC,
             mb_inc:  1'b0,
             mem_req: 1'b0,
             mem_we:  1'b0};
    case (state)
      pdp8_pkg::LD_PC: ctrl.pc_op = pdp8_pkg::PC_LOAD_SR;
      pdp8_pkg::FETCH: begin
        ctrl.mem_req = 1'b1;
        ctrl.rd_dest = pdp8_pkg::RD_IR;
      end
      pdp8_pkg::DECODE: begin
        ctrl.pc_op = pdp8_pkg::PC_INC;
        ctrl.ea_op = pdp8_pkg::EA_FORM;   // Page taken from the PC before it moves
      end
      pdp8_pkg::EA_IND: begin
        ctrl.mem_req = 1'b1;
        ctrl.ad_sel  = pdp8_pkg::AD_EA;
        ctrl.rd_dest = pdp8_pkg::RD_EA;
        ctrl.ea_op   = pdp8_pkg::EA_LOAD_RD;
      end
      pdp8_pkg::AND_RD, pdp8_pkg::TAD_RD, pdp8_pkg::ISZ_RD: begin
        ctrl.mem_req = 1'b1;
        ctrl.ad_sel  = pdp8_pkg::AD_EA;
        ctrl.rd_dest = pdp8_pkg::RD_MB;
        if (state == pdp8_pkg::AND_RD) ctrl.ac_op = pdp8_pkg::AC_AND_MB;
        if (state == pdp8_pkg::TAD_RD) ctrl.ac_op = pdp8_pkg::AC_TAD_MB;
      end
      pdp8_pkg::ISZ_INC: ctrl.mb_inc = 1'b1;
      pdp8_pkg::ISZ_WR: begin
        ctrl.mem_req = 1'b1;
        ctrl.mem_we  = 1'b1;
        ctrl.ad_sel  = pdp8_pkg::AD_EA;
        ctrl.wd_sel  = pdp8_pkg::WD_MB;
      end
      pdp8_pkg::ISZ_SKIP: if (mb_zero) ctrl.pc_op = pdp8_pkg::PC_INC;
      pdp8_pkg::DCA_WR: begin
        ctrl.mem_req = 1'b1;
        ctrl.mem_we  = 1'b1;
        ctrl.ad_sel  = pdp8_pkg::AD_EA;
        ctrl.ac_op   = pdp8_pkg::AC_CLEAR;  // Takes effect on done
      end
      pdp8_pkg::JMS_WR: begin
        ctrl.mem_req = 1'b1;
        ctrl.mem_we  = 1'b1;
        ctrl.ad_sel  = pdp8_pkg::AD_EA;
        ctrl.wd_sel  = pdp8_pkg::WD_PC;     // Return address
        ctrl.pc_op   = pdp8_pkg::PC_LOAD_EA_P1;
      end
      pdp8_pkg::JMP_1: ctrl.pc_op = pdp8_pkg::PC_LOAD_EA;
      pdp8_pkg::OPR_1: begin
        if (ir.operate.opcode == pdp8_pkg::OPR && !ir.operate.group)
          ctrl.ac_op = pdp8_pkg::AC_OPERATE;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/cpu_datapath.sv ====
// ####################
// CPU registers, adder, group 1 operate logic and the CPU memory request
// ####################
`default_nettype none

module cpu_datapath (
  input  logic                clock,
  input  logic                resetN,
  input  pdp8_pkg::cpu_ctrl_t ctrl,
  input  pdp8_pkg::word_t     sr,
  input  pdp8_pkg::mem_rsp_t  rsp,
  output pdp8_pkg::mem_req_t  req,
  output pdp8_pkg::instr_u    ir,
  output logic                mb_zero,
  output pdp8_pkg::word_t     ac,
  output logic                link,
  output pdp8_pkg::addr_t     pc
);

  pdp8_pkg::word_t         mb;
  pdp8_pkg::addr_t         ea;
  pdp8_pkg::addr_t         ea_form;
  pdp8_pkg::rd_dest_e      rd_to;
  logic                    upd;
  logic [pdp8_pkg::WORD_W:0] tad_sum;   // Link and AC as one 13-bit value
  logic [pdp8_pkg::WORD_W:0] opr_res;

  // Updates named by a memory state wait for that state's done
  assign upd   = !ctrl.mem_req || rsp.done;
  assign rd_to = rsp.done ? ctrl.rd_dest : pdp8_pkg::RD_NONE;

  assign mb_zero = (mb == '0);
  assign tad_sum = {link, ac} + {1'b0, rsp.rdata};    // Carry out flips the link

  always_comb begin
    ea_form = pdp8_pkg::addr_t'(ir.mem_ref.offset);
    if (ir.mem_ref.current_page)
      ea_form[pdp8_pkg::ADDR_W-1:7] = pc[pdp8_pkg::ADDR_W-1:7];
  end

  // Group 1: clear, complement, increment, then rotate
  always_comb begin
    opr_res = {link, ac};
    if (ir.operate.cla) opr_res[pdp8_pkg::WORD_W-1:0] = '0;
    if (ir.operate.cll) opr_res[pdp8_pkg::WORD_W] = 1'b0;
    if (ir.operate.cma) opr_res[pdp8_pkg::WORD_W-1:0] = ~opr_res[pdp8_pkg::WORD_W-1:0];
    if (ir.operate.cml) opr_res[pdp8_pkg::WORD_W] = ~opr_res[pdp8_pkg::WORD_W];
    if (ir.operate.iac) opr_res = opr_res + 1'b1;
    if (ir.operate.rar) opr_res = {opr_res[0], opr_res[pdp8_pkg::WORD_W:1]};
    if (ir.operate.ral) opr_res = {opr_res[pdp8_pkg::WORD_W-1:0], opr_res[pdp8_pkg::WORD_W]};
  end

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      ac   <= '0;
      link <= 1'b0;
      pc   <= '0;
    end else if (upd) begin
      case (ctrl.ac_op)
        pdp8_pkg::AC_CLEAR:   ac <= '0;
        pdp8_pkg::AC_AND_MB:  ac <= ac & rsp.rdata;   // Operand is the word landing in MB
        pdp8_pkg::AC_TAD_MB:  {link, ac} <= tad_sum;
        pdp8_pkg::AC_OPERATE: {link, ac} <= opr_res;
        default: ;
      endcase
      case (ctrl.pc_op)
        pdp8_pkg::PC_INC:        pc <= pc + 1'b1;
        pdp8_pkg::PC_LOAD_SR:    pc <= sr;
        pdp8_pkg::PC_LOAD_EA:    pc <= ea;
        pdp8_pkg::PC_LOAD_EA_P1: pc <= ea + 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (rd_to == pdp8_pkg::RD_IR)
      ir <= pdp8_pkg::instr_u'(rsp.rdata);
    if (rd_to == pdp8_pkg::RD_MB)
      mb <= rsp.rdata;
    else if (ctrl.mb_inc)
      mb <= mb + 1'b1;
    case (ctrl.ea_op)
      pdp8_pkg::EA_FORM:    ea <= ea_form;
      pdp8_pkg::EA_LOAD_RD: if (rd_to == pdp8_pkg::RD_EA) ea <= rsp.rdata;  // Indirect
      default: ;
    endcase
  end

  always_comb begin
    req.req  = ctrl.mem_req;
    req.we   = ctrl.mem_we;
    req.addr = (ctrl.ad_sel == pdp8_pkg::AD_EA) ? ea : pc;
    case (ctrl.wd_sel)
      pdp8_pkg::WD_MB: req.wdata = mb;
      pdp8_pkg::WD_PC: req.wdata = pc;
      default:         req.wdata = ac;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/front_panel.sv ====
// ####################
// Panel address register with one pending deposit or examine at a time
// ####################
`default_nettype none

module front_panel (
  input  logic               clock,
  input  logic               resetN,
  input  pdp8_pkg::word_t    sr,
  input  logic               load_addr,
  input  logic               deposit,
  input  logic               examine,
  input  pdp8_pkg::mem_rsp_t rsp,
  output pdp8_pkg::mem_req_t req,
  output pdp8_pkg::word_t    panel_data,
  output logic               panel_valid,
  output logic               panel_busy
);

  pdp8_pkg::addr_t panel_addr;
  pdp8_pkg::word_t wdata;
  logic            write_op;

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      panel_addr  <= '0;
      wdata       <= '0;
      write_op    <= 1'b0;
      panel_busy  <= 1'b0;
      panel_data  <= '0;
      panel_valid <= 1'b0;
    end else begin
      panel_valid <= 1'b0;
      if (panel_busy) begin
        if (rsp.done) begin
          panel_busy <= 1'b0;
          panel_addr <= panel_addr + 1'b1;
          if (!write_op) begin
            panel_data  <= rsp.rdata;
            panel_valid <= 1'b1;
          end
        end
      end else if (deposit || examine) begin
        panel_busy <= 1'b1;
        write_op   <= deposit;        // Deposit wins a tie
        wdata      <= sr;
      end else if (load_addr) begin
        panel_addr <= sr;
      end
    end
  end

  assign req = '{req: panel_busy, we: write_op, addr: panel_addr, wdata: wdata};

endmodule

`default_nettype wire

// ==== rtl/memory_arbiter.sv ====
// ####################
// Shares the memory port, CPU first; returns done to the granted side
// ####################
`default_nettype none

module memory_arbiter (
  input  logic               clock,
  input  logic               resetN,
  input  pdp8_pkg::mem_req_t cpu_req,
  input  pdp8_pkg::mem_req_t panel_req,
  input  pdp8_pkg::word_t    mem_rdata,
  output pdp8_pkg::mem_rsp_t cpu_rsp,
  output pdp8_pkg::mem_rsp_t panel_rsp,
  output logic               mem_we,
  output logic               mem_en,
  output pdp8_pkg::addr_t    mem_addr,
  output pdp8_pkg::word_t    mem_wdata
);

  logic done_due;        // An access went out last cycle
  logic cpu_owned;       // That access belonged to the CPU
  logic grant_cpu, grant_panel;

  // Requests are still held in their done cycle, so no grant then
  assign grant_cpu   = cpu_req.req && !done_due;
  assign grant_panel = panel_req.req && !cpu_req.req && !done_due;

  assign mem_en    = grant_cpu || grant_panel;
  assign mem_we    = grant_cpu ? cpu_req.we    : (grant_panel && panel_req.we);
  assign mem_addr  = grant_cpu ? cpu_req.addr  : panel_req.addr;
  assign mem_wdata = grant_cpu ? cpu_req.wdata : panel_req.wdata;

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      done_due  <= 1'b0;
      cpu_owned <= 1'b0;
    end else begin
      done_due  <= mem_en;
      cpu_owned <= grant_cpu;
    end
  end

  assign cpu_rsp.done    = done_due && cpu_owned;
  assign cpu_rsp.rdata   = mem_rdata;
  assign panel_rsp.done  = done_due && !cpu_owned;
  assign panel_rsp.rdata = mem_rdata;

endmodule

`default_nettype wire

// ==== rtl/core_memory.sv ====
// ####################
// Core memory array with a registered one-cycle read
// ####################
`default_nettype none

module core_memory #(
  parameter int MEM_WORDS = 4096
) (
  input  logic            clock,
  input  logic            en,
  input  logic            we,
  input  pdp8_pkg::addr_t addr,
  input  pdp8_pkg::word_t wdata,
  output pdp8_pkg::word_t rdata
);

  localparam int AW = $clog2(MEM_WORDS);

  pdp8_pkg::word_t mem [MEM_WORDS];
  logic [AW-1:0]   index;

  assign index = addr[AW-1:0];      // Upper address bits wrap

  always_ff @(posedge clock) begin
    if (en) begin
      if (we)
        mem[index] <= wdata;
      else
        rdata <= mem[index];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pdp8_pkg.sv ====
// ####################
// Shared widths, instruction views, memory port and CPU control types
// ####################
`default_nettype none

package pdp8_pkg;

  localparam int WORD_W = 12;
  localparam int ADDR_W = 12;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;

  localparam word_t HLT_WORD = 12'o7402;

  typedef enum logic [2:0] {
    AND, TAD, ISZ, DCA, JMS, JMP, IOT, OPR
  } opcode_e;

  // IR read either as a memory-reference word or as an operate word
  typedef union packed {
    struct packed {
      opcode_e    opcode;
      logic       indirect;
      logic       current_page;
      logic [6:0] offset;
    } mem_ref;
    struct packed {
      opcode_e opcode;
      logic    group;            // 0 selects group 1
      logic    cla;
      logic    cll;
      logic    cma;
      logic    cml;
      logic    rar;
      logic    ral;
      logic    twice;            // Not implemented
      logic    iac;
    } operate;
  } instr_u;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  done;
    word_t rdata;
  } mem_rsp_t;

  typedef enum logic [2:0] {AC_NC, AC_CLEAR, AC_AND_MB, AC_TAD_MB, AC_OPERATE} ac_op_e;
  typedef enum logic [2:0] {PC_NC, PC_INC, PC_LOAD_SR, PC_LOAD_EA, PC_LOAD_EA_P1} pc_op_e;
  typedef enum logic [1:0] {EA_NC, EA_FORM, EA_LOAD_RD} ea_op_e;
  typedef enum logic [1:0] {RD_NONE, RD_IR, RD_MB, RD_EA} rd_dest_e;
  typedef enum logic [1:0] {WD_AC, WD_MB, WD_PC, WD_SR} wd_sel_e;
  typedef enum logic [1:0] {AD_PC, AD_EA} ad_sel_e;

  typedef struct packed {
    ac_op_e   ac_op;
    pc_op_e   pc_op;
    ea_op_e   ea_op;
    rd_dest_e rd_dest;           // Where read data lands on done
    wd_sel_e  wd_sel;
    ad_sel_e  ad_sel;
    logic     mb_inc;
    logic     mem_req;
    logic     mem_we;
  } cpu_ctrl_t;

  typedef enum logic [4:0] {
    IDLE, FETCH, DECODE, EA_IND,
    AND_RD, TAD_RD,
    ISZ_RD, ISZ_INC, ISZ_WR, ISZ_SKIP,
    DCA_WR, JMS_WR, JMP_1, OPR_1, LD_PC
  } cpu_state_e;

endpackage

`default_nettype wire
